/* sim.f */
common/rv_pkg.sv
alu/alu.sv
hdl/issue_decode.sv
hdl/branch_unit.sv
hdl/exec_stage.sv
dv/exec_stage_props.sv
dv/exec_stage_tb.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert
TOP       ?= exec_stage_tb
RTL_TOP   ?= exec_stage
FILELIST  ?= sim.f
PASS_MSG  := Simulation completed successfully

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir

/* dv/exec_stage_tb.sv */
`timescale 1ns/1ps

module exec_stage_tb;

    localparam logic [6:0] k_op    = rv_pkg::opc_op;
    localparam logic [6:0] k_imm   = rv_pkg::opc_op_imm;
    localparam logic [6:0] k_lui   = rv_pkg::opc_lui;
    localparam logic [6:0] k_auipc = rv_pkg::opc_auipc;
    localparam logic [6:0] k_br    = rv_pkg::opc_branch;
    localparam logic [6:0] k_jal   = rv_pkg::opc_jal;
    localparam logic [6:0] k_jalr  = rv_pkg::opc_jalr;
    localparam logic [6:0] k_load  = 7'b0000011;        // Not supported by the stage

    typedef struct {
        logic [6:0]  opc;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [31:0] rs1;
        logic [31:0] rs2;
        logic [31:0] imm;
        logic [31:0] pc;
        logic [31:0] res;
        logic        chk;           // Result compared
        logic        taken;
        logic [31:0] target;
        logic        ill;
        logic [4:0]  rd;
    } row_t;

    logic                    clk;
    logic                    reset;
    logic                    issue_valid;
    logic [6:0]              opcode;
    logic [2:0]              funct3;
    logic [6:0]              funct7;
    logic [4:0]              rd_index;
    logic [rv_pkg::xlen-1:0] rs1_value;
    logic [rv_pkg::xlen-1:0] rs2_value;
    logic [rv_pkg::xlen-1:0] imm;
    logic [rv_pkg::xlen-1:0] pc;
    logic                    result_valid;
    logic [rv_pkg::xlen-1:0] result;
    logic [4:0]              result_rd;
    logic                    branch_taken;
    logic [rv_pkg::xlen-1:0] branch_target;
    logic                    illegal;

    row_t        table_q[$];
    row_t        exp_q[$];
    int          errors = 0;
    int          checked = 0;
    logic [31:0] lfsr = 32'd80471;
    logic [4:0]  rd_cnt = 5'd1;

    exec_stage i_dut (.*);

    always #50 clk = ~clk;

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
        end
        return v;
    endfunction

    // Reference for R-type results, written from the RV32IM rules
    function automatic logic [31:0] ref_rtype(input logic [2:0] f3, input logic [6:0] f7,
                                              input logic [31:0] a, input logic [31:0] b);
        longint     sa;
        longint     sb;
        logic [63:0] p;
        logic        ovf;
        sa = longint'($signed(a));
        sb = longint'($signed(b));
        ovf = (a == 32'h80000000) && (b == 32'hffffffff);
        if (f7 == 7'h01) begin
            case (f3)
                3'd0: begin
                    p = sa * sb;
                    return p[31:0];
                end
                3'd1: begin
                    p = sa * sb;
                    return p[63:32];
                end
                3'd2: begin
                    p = sa * longint'({32'd0, b});
                    return p[63:32];
                end
                3'd3: begin
                    p = {32'd0, a} * {32'd0, b};
                    return p[63:32];
                end
                3'd4: return (b == 0) ? 32'hffffffff : (ovf ? a : 32'(sa / sb));
                3'd5: return (b == 0) ? 32'hffffffff : a / b;
                3'd6: return (b == 0) ? a : (ovf ? 32'd0 : 32'(sa % sb));
                default: return (b == 0) ? a : a % b;
            endcase
        end
        case (f3)
            3'd0: return (f7 == 7'h20) ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return {31'd0, sa < sb};
            3'd3: return {31'd0, a < b};
            3'd4: return a ^ b;
            3'd5: return (f7 == 7'h20) ? 32'(sa >>> b[4:0]) : a >> b[4:0];
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic add_row(input logic [6:0] opc, input logic [2:0] f3, input logic [6:0] f7,
                           input logic [31:0] rs1, input logic [31:0] rs2,
                           input logic [31:0] imm_v, input logic [31:0] pc_v,
                           input logic [31:0] res, input logic chk, input logic tk,
                           input logic [31:0] tgt, input logic ill);
        row_t r;
        r = '{opc, f3, f7, rs1, rs2, imm_v, pc_v, res, chk, tk, tgt, ill, 5'd0};
        table_q.push_back(r);
    endtask

    // Drives one strobe at the rising edge and queues what should come back
    task automatic issue(input row_t r);
        @(posedge clk);
        r.rd = (r.opc == k_br) ? 5'd0 : rd_cnt;     // Branches write no register
        issue_valid <= 1'b1;
        opcode      <= r.opc;
        funct3      <= r.f3;
        funct7      <= r.f7;
        rd_index    <= rd_cnt;
        rs1_value   <= r.rs1;
        rs2_value   <= r.rs2;
        imm         <= r.imm;
        pc          <= r.pc;
        rd_cnt      = rd_cnt + 5'd1;
        exp_q.push_back(r);
    endtask

    task automatic report(input string what, input logic [31:0] got, input logic [31:0] exp);
        $display("FAIL %0t: %s got %h expected %h", $time, what, got, exp);
        errors++;
    endtask

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $finish;
    endtask

    always @(negedge clk) begin
        row_t e;
        if (!reset && result_valid) begin
            if (exp_q.size() == 0) begin
                $display("Error at %0t: result_valid with no instruction pending", $time);
                errors++;
            end else begin
                e = exp_q.pop_front();
                checked++;
                if (e.chk && result !== e.res) report("result", result, e.res);
                if (result_rd !== e.rd) report("result_rd", 32'(result_rd), 32'(e.rd));
                if (branch_taken !== e.taken) begin
                    report("branch_taken", 32'(branch_taken), 32'(e.taken));
                end
                if ((e.taken || (e.opc == k_br && !e.ill)) && branch_target !== e.target) begin
                    report("branch_target", branch_target, e.target);
                end
                if (illegal !== e.ill) report("illegal", 32'(illegal), 32'(e.ill));
            end
        end
    end

    task automatic wait_drained(output bit drained);
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < 20) begin
            @(negedge clk);
            #1;
            n++;
        end
        drained = (exp_q.size() == 0);
        if (!drained) begin
            $display("Timeout: results missing after issue");
            errors++;
        end
    endtask

    initial begin
        row_t r;
        logic [1:0] sel;
        bit drained;
        clk = 1'b0;
        reset = 1'b1;
        issue_valid = 1'b0;
        opcode = '0;
        funct3 = '0;
        funct7 = '0;
        rd_index = '0;
        rs1_value = '0;
        rs2_value = '0;
        imm = '0;
        pc = '0;
        // opc     f3    f7     rs1           rs2           imm           pc
        //   result        chk taken target     illegal
        add_row(k_op, 3'd0, 7'h00, 32'h5, 32'h7, 0, 0, 32'hc, 1, 0, 0, 0);
        add_row(k_op, 3'd0, 7'h20, 32'h5, 32'h7, 0, 0, 32'hfffffffe, 1, 0, 0, 0);
        add_row(k_op, 3'd1, 7'h00, 32'h1, 32'h23, 0, 0, 32'h8, 1, 0, 0, 0);
        add_row(k_op, 3'd5, 7'h00, 32'h80000000, 32'h21, 0, 0, 32'h40000000, 1, 0, 0, 0);
        add_row(k_op, 3'd5, 7'h20, 32'h80000000, 32'h3f, 0, 0, 32'hffffffff, 1, 0, 0, 0);
        add_row(k_op, 3'd2, 7'h00, 32'hffffffff, 32'h1, 0, 0, 32'h1, 1, 0, 0, 0);
        add_row(k_op, 3'd3, 7'h00, 32'hffffffff, 32'h1, 0, 0, 32'h0, 1, 0, 0, 0);
        add_row(k_op, 3'd4, 7'h00, 32'hf0f0f0f0, 32'h0ff00ff0, 0, 0, 32'hff00ff00, 1, 0, 0, 0);
        add_row(k_op, 3'd6, 7'h00, 32'hf0, 32'h0f, 0, 0, 32'hff, 1, 0, 0, 0);
        add_row(k_op, 3'd7, 7'h00, 32'hf0, 32'h3c, 0, 0, 32'h30, 1, 0, 0, 0);
        add_row(k_op, 3'd0, 7'h01, 32'hfffffffe, 32'h80000000, 0, 0, 32'h0, 1, 0, 0, 0);
        add_row(k_op, 3'd1, 7'h01, 32'hfffffffe, 32'h80000000, 0, 0, 32'h1, 1, 0, 0, 0);
        add_row(k_op, 3'd2, 7'h01, 32'hfffffffe, 32'h80000000, 0, 0, 32'hffffffff, 1, 0, 0, 0);
        add_row(k_op, 3'd3, 7'h01, 32'hfffffffe, 32'h80000000, 0, 0, 32'h7fffffff, 1, 0, 0, 0);
        add_row(k_op, 3'd4, 7'h01, 32'h1234, 32'h0, 0, 0, 32'hffffffff, 1, 0, 0, 0);
        add_row(k_op, 3'd5, 7'h01, 32'h1234, 32'h0, 0, 0, 32'hffffffff, 1, 0, 0, 0);
        add_row(k_op, 3'd6, 7'h01, 32'h1234, 32'h0, 0, 0, 32'h1234, 1, 0, 0, 0);
        add_row(k_op, 3'd7, 7'h01, 32'h1234, 32'h0, 0, 0, 32'h1234, 1, 0, 0, 0);
        add_row(k_op, 3'd4, 7'h01, 32'h80000000, 32'hffffffff, 0, 0, 32'h80000000, 1, 0, 0, 0);
        add_row(k_op, 3'd6, 7'h01, 32'h80000000, 32'hffffffff, 0, 0, 32'h0, 1, 0, 0, 0);
        add_row(k_op, 3'd4, 7'h01, 32'hfffffff9, 32'h2, 0, 0, 32'hfffffffd, 1, 0, 0, 0);
        add_row(k_op, 3'd6, 7'h01, 32'hfffffff9, 32'h2, 0, 0, 32'hffffffff, 1, 0, 0, 0);
        add_row(k_imm, 3'd0, 7'h00, 32'ha, 0, 32'hffffffff, 0, 32'h9, 1, 0, 0, 0);
        add_row(k_imm, 3'd5, 7'h20, 32'hf0000000, 0, 32'h4, 0, 32'hff000000, 1, 0, 0, 0);
        add_row(k_imm, 3'd3, 7'h00, 32'h0, 0, 32'h1, 0, 32'h1, 1, 0, 0, 0);
        add_row(k_lui, 3'd0, 7'h00, 32'h55, 0, 32'h12345000, 0, 32'h12345000, 1, 0, 0, 0);
        add_row(k_auipc, 3'd0, 7'h00, 32'h55, 0, 32'h2000, 32'h1000, 32'h3000, 1, 0, 0, 0);
        add_row(k_br, 3'd0, 7'h00, 32'h3, 32'h3, 32'h40, 32'h100, 0, 0, 1, 32'h140, 0);
        add_row(k_br, 3'd0, 7'h00, 32'h3, 32'h4, 32'h40, 32'h100, 0, 0, 0, 32'h140, 0);
        add_row(k_br, 3'd1, 7'h00, 32'h3, 32'h4, 32'h40, 32'h100, 0, 0, 1, 32'h140, 0);
        add_row(k_br, 3'd1, 7'h00, 32'h3, 32'h3, 32'h40, 32'h100, 0, 0, 0, 32'h140, 0);
        add_row(k_br, 3'd4, 7'h00, 32'hffffffff, 32'h1, 32'h40, 32'h100, 0, 0, 1, 32'h140, 0);
        add_row(k_br, 3'd4, 7'h00, 32'h1, 32'hffffffff, 32'h40, 32'h100, 0, 0, 0, 32'h140, 0);
        add_row(k_br, 3'd5, 7'h00, 32'h1, 32'hffffffff, 32'h40, 32'h100, 0, 0, 1, 32'h140, 0);
        add_row(k_br, 3'd5, 7'h00, 32'hffffffff, 32'h1, 32'h40, 32'h100, 0, 0, 0, 32'h140, 0);
        add_row(k_br, 3'd6, 7'h00, 32'h1, 32'hffffffff, 32'h40, 32'h100, 0, 0, 1, 32'h140, 0);
        add_row(k_br, 3'd6, 7'h00, 32'hffffffff, 32'h1, 32'h40, 32'h100, 0, 0, 0, 32'h140, 0);
        add_row(k_br, 3'd7, 7'h00, 32'hffffffff, 32'h1, 32'h40, 32'h100, 0, 0, 1, 32'h140, 0);
        add_row(k_br, 3'd7, 7'h00, 32'h1, 32'hffffffff, 32'h40, 32'h100, 0, 0, 0, 32'h140, 0);
        add_row(k_jal, 3'd0, 7'h00, 32'h0, 0, 32'h80, 32'h200, 32'h204, 1, 1, 32'h280, 0);
        add_row(k_jalr, 3'd0, 7'h00, 32'h301, 0, 32'h10, 32'h400, 32'h404, 1, 1, 32'h310, 0);
        add_row(k_load, 3'd2, 7'h00, 32'h9, 32'h9, 32'h4, 0, 32'h0, 1, 0, 0, 1);
        add_row(k_op, 3'd0, 7'h02, 32'h9, 32'h9, 0, 0, 32'h0, 1, 0, 0, 1);
        add_row(k_op, 3'd1, 7'h20, 32'h9, 32'h9, 0, 0, 32'h0, 1, 0, 0, 1);
        add_row(k_br, 3'd2, 7'h00, 32'h3, 32'h3, 32'h40, 32'h100, 32'h0, 1, 0, 0, 1);
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        foreach (table_q[i]) issue(table_q[i]);     // Back-to-back strobes
        @(posedge clk);
        issue_valid <= 1'b0;
        wait_drained(drained);
        for (int k = 0; k < 200 && drained; k++) begin
            r = '{k_op, 3'd0, 7'h00, 0, 0, 0, 0, 0, 1'b1, 1'b0, 0, 1'b0, 5'd0};
            r.f3 = 3'(rand_bits(3));
            sel = 2'(rand_bits(2));
            if (sel == 2'd1 && (r.f3 == 3'd0 || r.f3 == 3'd5)) r.f7 = 7'h20;
            else if (sel[1]) r.f7 = 7'h01;
            r.rs1 = rand_bits(32);
            r.rs2 = rand_bits(32);
            r.res = ref_rtype(r.f3, r.f7, r.rs1, r.rs2);
            issue(r);
            @(posedge clk);
            issue_valid <= 1'b0;
            wait_drained(drained);
        end
        $display("Checked %0d results, %0d errors", checked, errors);
        if (errors == 0 && checked == table_q.size() + 200) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        #10ms;
        abort_run("Timeout: simulation ran past its time limit");
    end

endmodule

/* dv/exec_stage_props.sv */
`timescale 1ns/1ps

module exec_stage_props (
    input logic clk,
    input logic reset,
    input logic issue_valid,
    input logic result_valid,
    input logic branch_taken,
    input logic illegal
);

    // One result beat per strobe, one cycle later
    strobe_follow: assert property (@(posedge clk)
        !reset && !$past(reset) |-> result_valid == $past(issue_valid))
        else $error("result_valid does not follow issue_valid by one cycle");

    reset_quiet: assert property (@(posedge clk)
        reset |=> !result_valid && !branch_taken && !illegal)
        else $error("outputs active during or right after reset");

    taken_not_illegal: assert property (@(posedge clk)
        disable iff (reset) !(branch_taken && illegal))
        else $error("branch_taken and illegal both set");

endmodule

bind exec_stage exec_stage_props i_props (
    .clk          (clk),
    .reset        (reset),
    .issue_valid  (issue_valid),
    .result_valid (result_valid),
    .branch_taken (branch_taken),
    .illegal      (illegal)
);

/* hdl/exec_stage.sv */
`timescale 1ns/1ps

module exec_stage (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    issue_valid,
    input  logic [6:0]              opcode,
    input  logic [2:0]              funct3,
    input  logic [6:0]              funct7,
    input  logic [4:0]              rd_index,
    input  logic [rv_pkg::xlen-1:0] rs1_value,
    input  logic [rv_pkg::xlen-1:0] rs2_value,
    input  logic [rv_pkg::xlen-1:0] imm,
    input  logic [rv_pkg::xlen-1:0] pc,
    output logic                    result_valid,
    output logic [rv_pkg::xlen-1:0] result,
    output logic [4:0]              result_rd,
    output logic                    branch_taken,
    output logic [rv_pkg::xlen-1:0] branch_target,
    output logic                    illegal
);

    logic [rv_pkg::xlen-1:0] alu_op1;
    logic [rv_pkg::xlen-1:0] alu_op2;
    rv_pkg::alu_op_e         alu_sel;
    logic                    dec_illegal;
    logic [rv_pkg::xlen-1:0] alu_out;
    logic                    taken;
    logic [rv_pkg::xlen-1:0] target;
    logic                    is_branch;

    assign is_branch = (opcode == rv_pkg::opc_branch);  // Writes no register

    issue_decode i_decode (
        .opcode    (opcode),
        .funct3    (funct3),
        .funct7    (funct7),
        .rs1_value (rs1_value),
        .rs2_value (rs2_value),
        .imm       (imm),
        .pc        (pc),
        .alu_op1   (alu_op1),
        .alu_op2   (alu_op2),
        .alu_sel   (alu_sel),
        .illegal   (dec_illegal)
    );

    alu i_alu (
        .alu_op1 (alu_op1),
        .alu_op2 (alu_op2),
        .alu_sel (alu_sel),
        .alu_out (alu_out)
    );

    branch_unit i_branch (
        .opcode    (opcode),
        .funct3    (funct3),
        .rs1_value (rs1_value),
        .rs2_value (rs2_value),
        .imm       (imm),
        .pc        (pc),
        .taken     (taken),
        .target    (target)
    );

    // Flags only rise for the cycle after a strobe
    always_ff @(posedge clk) begin
        if (reset) begin
            result_valid <= 1'b0;
            branch_taken <= 1'b0;
            illegal      <= 1'b0;
        end else begin
            result_valid <= issue_valid;
            branch_taken <= issue_valid && taken && !dec_illegal;
            illegal      <= issue_valid && dec_illegal;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_valid) begin
            result        <= dec_illegal ? '0 : alu_out;    // Zero for illegal encodings
            result_rd     <= is_branch ? 5'd0 : rd_index;
            branch_target <= target;
        end
    end

endmodule

/* hdl/branch_unit.sv */
`timescale 1ns/1ps

module branch_unit (
    input  logic [6:0]              opcode,
    input  logic [2:0]              funct3,
    input  logic [rv_pkg::xlen-1:0] rs1_value,
    input  logic [rv_pkg::xlen-1:0] rs2_value,
    input  logic [rv_pkg::xlen-1:0] imm,
    input  logic [rv_pkg::xlen-1:0] pc,
    output logic                    taken,
    output logic [rv_pkg::xlen-1:0] target
);

    logic                    is_eq;
    logic                    is_lt;         // Signed compare
    logic                    is_ltu;        // Unsigned compare
    logic                    cond_met;
    logic [rv_pkg::xlen-1:0] jalr_sum;

    assign is_eq    = (rs1_value == rs2_value);
    assign is_lt    = ($signed(rs1_value) < $signed(rs2_value));
    assign is_ltu   = (rs1_value < rs2_value);
    assign jalr_sum = rs1_value + imm;

    always_comb begin
        case (rv_pkg::branch_cond_e'(funct3))
            rv_pkg::beq:  cond_met = is_eq;
            rv_pkg::bne:  cond_met = !is_eq;
            rv_pkg::blt:  cond_met = is_lt;
            rv_pkg::bge:  cond_met = !is_lt;
            rv_pkg::bltu: cond_met = is_ltu;
            rv_pkg::bgeu: cond_met = !is_ltu;
            default:      cond_met = 1'b0;          // Undefined funct3
        endcase
    end

    always_comb begin
        case (opcode)
            rv_pkg::opc_branch: taken = cond_met;
            rv_pkg::opc_jal:    taken = 1'b1;
            rv_pkg::opc_jalr:   taken = 1'b1;
            default:            taken = 1'b0;
        endcase
        if (opcode == rv_pkg::opc_jalr) begin
            target = {jalr_sum[rv_pkg::xlen-1:1], 1'b0};    // Bit 0 cleared
        end else begin
            target = pc + imm;
        end
    end

endmodule

/* hdl/issue_decode.sv */
`timescale 1ns/1ps

module issue_decode (
    input  logic [6:0]              opcode,
    input  logic [2:0]              funct3,
    input  logic [6:0]              funct7,
    input  logic [rv_pkg::xlen-1:0] rs1_value,
    input  logic [rv_pkg::xlen-1:0] rs2_value,
    input  logic [rv_pkg::xlen-1:0] imm,
    input  logic [rv_pkg::xlen-1:0] pc,
    output logic [rv_pkg::xlen-1:0] alu_op1,
    output logic [rv_pkg::xlen-1:0] alu_op2,
    output rv_pkg::alu_op_e         alu_sel,
    output logic                    illegal
);

    rv_pkg::op1_src_e op1_src;
    rv_pkg::op2_src_e op2_src;
    rv_pkg::alu_op_e  base_op;      // Picked by funct3 alone
    rv_pkg::alu_op_e  muldiv_op;    // M extension row
    logic             is_f7_zero;
    logic             is_f7_alt;
    logic             is_f7_muldiv;
    logic             is_shift_r;   // SRL/SRA and their immediate forms

    assign is_f7_zero   = (funct7 == rv_pkg::f7_zero);
    assign is_f7_alt    = (funct7 == rv_pkg::f7_alt);
    assign is_f7_muldiv = (funct7 == rv_pkg::f7_muldiv);
    assign is_shift_r   = (funct3 == 3'b101);

    always_comb begin
        case (funct3)
            3'b000:  base_op = rv_pkg::alu_add;
            3'b001:  base_op = rv_pkg::alu_sll;
            3'b010:  base_op = rv_pkg::alu_slt;
            3'b011:  base_op = rv_pkg::alu_sltu;
            3'b100:  base_op = rv_pkg::alu_xor;
            3'b101:  base_op = rv_pkg::alu_srl;     // SRA comes from funct7
            3'b110:  base_op = rv_pkg::alu_or;
            default: base_op = rv_pkg::alu_and;
        endcase
    end

    always_comb begin
        case (funct3)
            3'b000:  muldiv_op = rv_pkg::alu_mul;
            3'b001:  muldiv_op = rv_pkg::alu_mulh;
            3'b010:  muldiv_op = rv_pkg::alu_mulhsu;
            3'b011:  muldiv_op = rv_pkg::alu_mulhu;
            3'b100:  muldiv_op = rv_pkg::alu_div;
            3'b101:  muldiv_op = rv_pkg::alu_divu;
            3'b110:  muldiv_op = rv_pkg::alu_rem;
            default: muldiv_op = rv_pkg::alu_remu;
        endcase
    end

    always_comb begin
        op1_src = rv_pkg::src1_reg1;
        op2_src = rv_pkg::src2_reg2;
        alu_sel = rv_pkg::alu_add;
        illegal = 1'b0;
        case (opcode)
            rv_pkg::opc_op: begin
                if (is_f7_zero) begin
                    alu_sel = base_op;
                end else if (is_f7_alt && funct3 == 3'b000) begin
                    alu_sel = rv_pkg::alu_sub;
                end else if (is_f7_alt && is_shift_r) begin
                    alu_sel = rv_pkg::alu_sra;
                end else if (is_f7_muldiv) begin
                    alu_sel = muldiv_op;
                end else begin
                    illegal = 1'b1;
                end
            end
            rv_pkg::opc_op_imm: begin
                op2_src = rv_pkg::src2_imm;
                alu_sel = base_op;
                if (funct3 == 3'b001) begin
                    illegal = !is_f7_zero;              // SLLI
                end else if (is_shift_r) begin
                    if (is_f7_alt) begin
                        alu_sel = rv_pkg::alu_sra;
                    end
                    illegal = !(is_f7_zero || is_f7_alt);
                end
            end
            rv_pkg::opc_lui: begin
                op1_src = rv_pkg::src1_zero;
                op2_src = rv_pkg::src2_imm;
            end
            rv_pkg::opc_auipc: begin
                op1_src = rv_pkg::src1_pc;
                op2_src = rv_pkg::src2_imm;
            end
            rv_pkg::opc_jal, rv_pkg::opc_jalr: begin
                op1_src = rv_pkg::src1_pc;              // Link address pc + 4
                op2_src = rv_pkg::src2_four;
            end
            rv_pkg::opc_branch: illegal = (funct3[2:1] == 2'b01);   // funct3 2 and 3 undefined
            default:            illegal = 1'b1;
        endcase
    end

    always_comb begin
        case (op1_src)
            rv_pkg::src1_reg1: alu_op1 = rs1_value;
            rv_pkg::src1_pc:   alu_op1 = pc;
            default:           alu_op1 = '0;
        endcase
        case (op2_src)
            rv_pkg::src2_reg2: alu_op2 = rs2_value;
            rv_pkg::src2_imm:  alu_op2 = imm;
            default:           alu_op2 = rv_pkg::xlen'(4);
        endcase
    end

endmodule

/* alu/alu.sv */
`timescale 1ns/1ps

module alu (
    input  logic [rv_pkg::xlen-1:0] alu_op1,
    input  logic [rv_pkg::xlen-1:0] alu_op2,
    input  rv_pkg::alu_op_e         alu_sel,
    output logic [rv_pkg::xlen-1:0] alu_out
);

    logic [rv_pkg::dxlen-1:0] op1_sext;     // Operands widened for the products
    logic [rv_pkg::dxlen-1:0] op1_zext;
    logic [rv_pkg::dxlen-1:0] op2_sext;
    logic [rv_pkg::dxlen-1:0] op2_zext;
    logic [rv_pkg::dxlen-1:0] prod_ss;      // Signed by signed
    logic [rv_pkg::dxlen-1:0] prod_su;      // Signed by unsigned
    logic [rv_pkg::dxlen-1:0] prod_uu;      // Unsigned by unsigned
    logic [4:0]               shamt;
    logic                     div_by_zero;
    logic                     div_overflow;

    assign op1_sext = {{rv_pkg::xlen{alu_op1[rv_pkg::xlen-1]}}, alu_op1};
    assign op1_zext = {{rv_pkg::xlen{1'b0}}, alu_op1};
    assign op2_sext = {{rv_pkg::xlen{alu_op2[rv_pkg::xlen-1]}}, alu_op2};
    assign op2_zext = {{rv_pkg::xlen{1'b0}}, alu_op2};

    // Extended operands make a plain modulo-2^64 product exact for every sign mix
    assign prod_ss = op1_sext * op2_sext;
    assign prod_su = op1_sext * op2_zext;
    assign prod_uu = op1_zext * op2_zext;

    assign shamt        = alu_op2[4:0];     // Only five bits count
    assign div_by_zero  = (alu_op2 == '0);
    assign div_overflow = (alu_op1 == rv_pkg::xlen_min) && (alu_op2 == '1);

    always_comb begin
        case (alu_sel)
            rv_pkg::alu_add:    alu_out = alu_op1 + alu_op2;
            rv_pkg::alu_sub:    alu_out = alu_op1 - alu_op2;
            rv_pkg::alu_sll:    alu_out = alu_op1 << shamt;
            rv_pkg::alu_slt: begin
                alu_out = {{(rv_pkg::xlen-1){1'b0}}, ($signed(alu_op1) < $signed(alu_op2))};
            end
            rv_pkg::alu_sltu: begin
                alu_out = {{(rv_pkg::xlen-1){1'b0}}, (alu_op1 < alu_op2)};
            end
            rv_pkg::alu_xor:    alu_out = alu_op1 ^ alu_op2;
            rv_pkg::alu_srl:    alu_out = alu_op1 >> shamt;
            rv_pkg::alu_sra:    alu_out = $signed(alu_op1) >>> shamt;
            rv_pkg::alu_or:     alu_out = alu_op1 | alu_op2;
            rv_pkg::alu_and:    alu_out = alu_op1 & alu_op2;
            rv_pkg::alu_mul:    alu_out = prod_ss[rv_pkg::xlen-1:0];    // Low half, any sign
            rv_pkg::alu_mulh:   alu_out = prod_ss[rv_pkg::dxlen-1:rv_pkg::xlen];
            rv_pkg::alu_mulhsu: alu_out = prod_su[rv_pkg::dxlen-1:rv_pkg::xlen];
            rv_pkg::alu_mulhu:  alu_out = prod_uu[rv_pkg::dxlen-1:rv_pkg::xlen];
            rv_pkg::alu_div: begin
                if (div_by_zero) begin
                    alu_out = '1;                                   // All ones
                end else if (div_overflow) begin
                    alu_out = alu_op1;                              // Quotient wraps to dividend
                end else begin
                    alu_out = $signed(alu_op1) / $signed(alu_op2);
                end
            end
            rv_pkg::alu_divu: begin
                if (div_by_zero) begin
                    alu_out = '1;
                end else begin
                    alu_out = alu_op1 / alu_op2;
                end
            end
            rv_pkg::alu_rem: begin
                if (div_by_zero) begin
                    alu_out = alu_op1;                              // Remainder is the dividend
                end else if (div_overflow) begin
                    alu_out = '0;
                end else begin
                    alu_out = $signed(alu_op1) % $signed(alu_op2);
                end
            end
            rv_pkg::alu_remu: begin
                if (div_by_zero) begin
                    alu_out = alu_op1;
                end else begin
                    alu_out = alu_op1 % alu_op2;
                end
            end
            default:            alu_out = '0;                       // Unused encodings
        endcase
    end

endmodule

/* common/rv_pkg.sv */
package rv_pkg;

    localparam int xlen  = 32;              // Data path width
    localparam int dxlen = 2 * xlen;        // Full product width

    localparam logic [xlen-1:0] xlen_min = {1'b1, {(xlen-1){1'b0}}};  // Most negative value

    localparam logic [6:0] f7_zero   = 7'h00;   // Plain base encoding
    localparam logic [6:0] f7_alt    = 7'h20;   // SUB and SRA/SRAI
    localparam logic [6:0] f7_muldiv = 7'h01;   // M extension, OP only

    typedef enum logic [6:0] {
        opc_op     = 7'b0110011,    // Register-register ALU
        opc_op_imm = 7'b0010011,    // Register-immediate ALU
        opc_lui    = 7'b0110111,
        opc_auipc  = 7'b0010111,
        opc_branch = 7'b1100011,
        opc_jal    = 7'b1101111,
        opc_jalr   = 7'b1100111
    } opcode_e;

    typedef enum logic [4:0] {
        alu_add    = 5'd0,
        alu_sub    = 5'd1,
        alu_sll    = 5'd2,
        alu_slt    = 5'd3,
        alu_sltu   = 5'd4,
        alu_xor    = 5'd5,
        alu_srl    = 5'd6,
        alu_sra    = 5'd7,
        alu_or     = 5'd8,
        alu_and    = 5'd9,
        alu_mul    = 5'd10,         // M extension from here on
        alu_mulh   = 5'd11,
        alu_mulhsu = 5'd12,
        alu_mulhu  = 5'd13,
        alu_div    = 5'd14,
        alu_divu   = 5'd15,
        alu_rem    = 5'd16,
        alu_remu   = 5'd17
    } alu_op_e;

    typedef enum logic [2:0] {
        beq  = 3'b000,
        bne  = 3'b001,
        blt  = 3'b100,
        bge  = 3'b101,
        bltu = 3'b110,
        bgeu = 3'b111
    } branch_cond_e;

    typedef enum logic [1:0] {src1_reg1, src1_pc, src1_zero} op1_src_e;
    typedef enum logic [1:0] {src2_reg2, src2_imm, src2_four} op2_src_e;

endpackage
